// ==== all.f ====
+incdir+verification
logic/lockstep_pkg.sv
logic/core_obs_if.sv
logic/program_store.sv
logic/secret_dmem.sv
logic/lockstep_core.sv
logic/divergence_checker.sv
logic/lockstep_top.sv
verification/lockstep_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := lockstep_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# a $fatal in the testbench makes the binary exit nonzero
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/lockstep_ref.svh ====
// encoders and lockstep reference model; at most max_steps instructions per run, regs start at zero
`ifndef lockstep_ref_svh
`define lockstep_ref_svh

localparam int max_steps = 32;

function automatic lockstep_pkg::word_t enc_addi(input lockstep_pkg::reg_addr_t rd,
                                                 input lockstep_pkg::reg_addr_t rs1,
                                                 input logic [11:0]             imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic lockstep_pkg::word_t enc_add(input lockstep_pkg::reg_addr_t rd,
                                                input lockstep_pkg::reg_addr_t rs1,
                                                input lockstep_pkg::reg_addr_t rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

function automatic lockstep_pkg::word_t enc_lw(input lockstep_pkg::reg_addr_t rd,
                                               input lockstep_pkg::reg_addr_t rs1,
                                               input logic [11:0]             imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

// runs all copies side by side, retires copy 0, flags the first load whose address differs
function automatic void run_reference(
    input  lockstep_pkg::word_t     prog [lockstep_pkg::prog_words],
    input  lockstep_pkg::word_t     dmem [lockstep_pkg::num_copies][lockstep_pkg::dmem_words],
    input  int                      steps,
    output int                      n_ret,
    output lockstep_pkg::reg_addr_t ret_rd [max_steps],
    output lockstep_pkg::word_t     ret_data [max_steps],
    output logic                    leak,
    output lockstep_pkg::word_t     leak_pc
);
    lockstep_pkg::word_t     regs [lockstep_pkg::num_copies][32];
    lockstep_pkg::word_t     result [lockstep_pkg::num_copies];
    lockstep_pkg::word_t     addr [lockstep_pkg::num_copies];
    lockstep_pkg::word_t     inst;
    lockstep_pkg::word_t     imm;
    lockstep_pkg::reg_addr_t rd;
    lockstep_pkg::reg_addr_t rs1;
    lockstep_pkg::reg_addr_t rs2;
    logic                    is_addi;
    logic                    is_add;
    logic                    is_lw;
    int                      slot;

    n_ret   = 0;
    leak    = 1'b0;
    leak_pc = '0;
    for (int c = 0; c < lockstep_pkg::num_copies; c++) begin
        for (int r = 0; r < 32; r++) begin
            regs[c][r] = '0;
        end
    end
    for (int s = 0; s < steps; s++) begin
        slot    = s % lockstep_pkg::prog_words;   // pc wraps
        inst    = prog[slot];
        rd      = inst[11:7];
        rs1     = inst[19:15];
        rs2     = inst[24:20];
        imm     = {{20{inst[31]}}, inst[31:20]};
        is_addi = inst[6:0] == 7'b0010011 && inst[14:12] == 3'b000;
        is_add  = inst[6:0] == 7'b0110011 && inst[14:12] == 3'b000 && inst[31:25] == 7'd0;
        is_lw   = inst[6:0] == 7'b0000011 && inst[14:12] == 3'b010;
        for (int c = 0; c < lockstep_pkg::num_copies; c++) begin
            addr[c] = regs[c][rs1] + imm;
            if (is_add) begin
                result[c] = regs[c][rs1] + regs[c][rs2];
            end else if (is_lw) begin
                result[c] = dmem[c][addr[c][5:2]];   // word index
            end else begin
                result[c] = regs[c][rs1] + imm;
            end
            if ((is_addi || is_add || is_lw) && rd != 5'd0) begin
                regs[c][rd] = result[c];
            end
            if (is_lw && !leak && addr[c] != addr[0]) begin
                leak    = 1'b1;
                leak_pc = lockstep_pkg::word_t'(slot * 4);
            end
        end
        if ((is_addi || is_add || is_lw) && rd != 5'd0) begin
            ret_rd[n_ret]   = rd;
            ret_data[n_ret] = result[0];
            n_ret++;
        end
    end
endfunction

`endif

// ==== verification/lockstep_tb.sv ====
// lockstep harness testbench; every scenario rewrites both memories and resets the cores
`default_nettype none

module lockstep_tb;

    timeunit 1ns;
    timeprecision 100ps;

    `include "lockstep_ref.svh"

    localparam int scenario_cycles = 80;   // load, reset, run and settle
    localparam int num_runs        = 12;
    localparam int max_cycles      = 2 * scenario_cycles * num_runs;

    logic                      clk;
    logic                      reset;
    logic                      prog_we;
    lockstep_pkg::mem_idx_t    prog_addr;
    lockstep_pkg::word_t       prog_data;
    logic                      dmem_we;
    lockstep_pkg::copy_idx_t   dmem_copy;
    lockstep_pkg::mem_idx_t    dmem_addr;
    lockstep_pkg::word_t       dmem_data;
    logic                      run;
    logic                      retire_valid;
    lockstep_pkg::reg_addr_t   retire_addr;
    lockstep_pkg::word_t       retire_data;
    logic                      leak;
    lockstep_pkg::word_t       leak_pc;

    lockstep_pkg::word_t       prog_img [lockstep_pkg::prog_words];
    lockstep_pkg::word_t       dmem_img [lockstep_pkg::num_copies][lockstep_pkg::dmem_words];
    lockstep_pkg::reg_addr_t   exp_rd_q [$];
    lockstep_pkg::word_t       exp_data_q [$];
    logic                      checking;   // monitor compares retires
    string                     test_name;
    int                        seed;
    int                        cycle_count;

    lockstep_top u_lockstep_top (
        .clk          (clk),
        .reset        (reset),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .dmem_we      (dmem_we),
        .dmem_copy    (dmem_copy),
        .dmem_addr    (dmem_addr),
        .dmem_data    (dmem_data),
        .run          (run),
        .retire_valid (retire_valid),
        .retire_addr  (retire_addr),
        .retire_data  (retire_data),
        .leak         (leak),
        .leak_pc      (leak_pc)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input lockstep_pkg::word_t expected,
                         input lockstep_pkg::word_t actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) next_cycle();
        reset = 1'b0;
    endtask

    task automatic fill_nops();
        for (int i = 0; i < lockstep_pkg::prog_words; i++) begin
            prog_img[i] = 32'h0000_0013;
        end
    endtask

    // copy, index and a mix of the index in every word
    task automatic fill_memories();
        for (int c = 0; c < lockstep_pkg::num_copies; c++) begin
            for (int i = 0; i < lockstep_pkg::dmem_words; i++) begin
                dmem_img[c][i] = {8'(c + 1), 8'(i), 8'(i * 7), 8'(~i)};
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < lockstep_pkg::prog_words; i++) begin
            prog_we   = 1'b1;
            prog_addr = lockstep_pkg::mem_idx_t'(i);
            prog_data = prog_img[i];
            next_cycle();
        end
        prog_we = 1'b0;
    endtask

    task automatic load_memories();
        for (int c = 0; c < lockstep_pkg::num_copies; c++) begin
            for (int i = 0; i < lockstep_pkg::dmem_words; i++) begin
                dmem_we   = 1'b1;
                dmem_copy = lockstep_pkg::copy_idx_t'(c);
                dmem_addr = lockstep_pkg::mem_idx_t'(i);
                dmem_data = dmem_img[c][i];
                next_cycle();
            end
        end
        dmem_we = 1'b0;
    endtask

    // random mix of addi, add, lw and an unsupported opcode, same memory in every copy
    task automatic randomize_run();
        lockstep_pkg::word_t r;
        lockstep_pkg::word_t w;
        for (int i = 0; i < lockstep_pkg::prog_words; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    prog_img[i] = enc_addi(r[6:2], r[11:7], r[23:12]);
                2'd1:    prog_img[i] = enc_add(r[6:2], r[11:7], r[16:12]);
                2'd2:    prog_img[i] = enc_lw(r[6:2], r[11:7], r[23:12]);
                default: prog_img[i] = {r[31:7], 7'b1100011};   // branch, runs as nop
            endcase
        end
        for (int i = 0; i < lockstep_pkg::dmem_words; i++) begin
            w = $random(seed);
            for (int c = 0; c < lockstep_pkg::num_copies; c++) begin
                dmem_img[c][i] = w;
            end
        end
    endtask

    task automatic run_scenario(input string name, input int steps);
        int                      n_ret;
        lockstep_pkg::reg_addr_t ret_rd [max_steps];
        lockstep_pkg::word_t     ret_data [max_steps];
        logic                    exp_leak;
        lockstep_pkg::word_t     exp_leak_pc;
        load_program();
        load_memories();
        apply_reset();
        run_reference(prog_img, dmem_img, steps, n_ret, ret_rd, ret_data, exp_leak, exp_leak_pc);
        for (int i = 0; i < n_ret; i++) begin
            exp_rd_q.push_back(ret_rd[i]);
            exp_data_q.push_back(ret_data[i]);
        end
        test_name = name;
        checking  = 1'b1;
        run       = 1'b1;
        repeat (steps + 1) next_cycle();   // first cycle executes the reset nop
        run = 1'b0;
        repeat (2) next_cycle();           // leak lags the load buffers by one edge
        checking = 1'b0;
        check($sformatf("%s retires left", name), 32'd0, exp_rd_q.size());
        check($sformatf("%s leak", name), lockstep_pkg::word_t'(exp_leak),
              lockstep_pkg::word_t'(leak));
        if (exp_leak) begin
            check($sformatf("%s leak_pc", name), exp_leak_pc, leak_pc);
        end
    endtask

    // retire stream of copy 0 against the model, sampled mid-cycle
    always @(negedge clk) begin
        if (checking && !reset && retire_valid) begin
            if (exp_rd_q.size() == 0) begin
                stop_with_failure($sformatf("%s: retire to x%0d that the model did not expect",
                                            test_name, retire_addr));
            end else begin
                check($sformatf("%s retire rd", test_name),
                      lockstep_pkg::word_t'(exp_rd_q.pop_front()),
                      lockstep_pkg::word_t'(retire_addr));
                check($sformatf("%s retire data", test_name), exp_data_q.pop_front(), retire_data);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            stop_with_failure($sformatf("timeout, run not finished after %0d cycles", max_cycles));
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        dmem_we     = 1'b0;
        dmem_copy   = '0;
        dmem_addr   = '0;
        dmem_data   = '0;
        run         = 1'b0;
        checking    = 1'b0;
        test_name   = "idle";
        seed        = 32'hd764582e;
        cycle_count = 0;

        // idle after reset, run low
        fill_nops();
        fill_memories();
        prog_img[0] = enc_addi(5'd1, 5'd0, 12'd1);
        load_program();
        load_memories();
        apply_reset();
        check("reset leak", 32'd0, lockstep_pkg::word_t'(leak));
        checking = 1'b1;
        repeat (6) begin
            next_cycle();
            check("idle retire_valid", 32'd0, lockstep_pkg::word_t'(retire_valid));
        end
        checking = 1'b0;

        fill_nops();
        prog_img[0] = enc_addi(5'd1, 5'd0, 12'd5);
        prog_img[1] = enc_addi(5'd2, 5'd0, 12'hffd);   // -3
        prog_img[2] = enc_add(5'd3, 5'd1, 5'd2);
        prog_img[3] = enc_addi(5'd0, 5'd1, 12'd7);     // x0 target
        prog_img[4] = enc_add(5'd0, 5'd1, 5'd1);
        prog_img[5] = enc_add(5'd4, 5'd3, 5'd0);
        prog_img[6] = enc_addi(5'd5, 5'd4, 12'h7ff);
        prog_img[7] = enc_addi(5'd6, 5'd5, 12'h800);
        prog_img[8] = enc_add(5'd7, 5'd6, 5'd6);
        run_scenario("alu", 16);

        // secrets differ, addresses do not
        fill_nops();
        dmem_img[1][2] = 32'h9999_aaaa;
        dmem_img[1][3] = 32'h5555_0001;
        prog_img[0] = enc_lw(5'd1, 5'd0, 12'd8);
        prog_img[1] = enc_lw(5'd2, 5'd0, 12'd12);
        prog_img[2] = enc_add(5'd3, 5'd1, 5'd2);
        run_scenario("fixed load", 16);

        // pointer chase through a secret
        fill_nops();
        fill_memories();
        dmem_img[0][2] = 32'd20;
        dmem_img[1][2] = 32'd36;
        prog_img[0] = enc_addi(5'd5, 5'd0, 12'd1);
        prog_img[1] = enc_lw(5'd1, 5'd0, 12'd8);
        prog_img[2] = enc_addi(5'd6, 5'd0, 12'd2);
        prog_img[3] = enc_lw(5'd2, 5'd1, 12'd0);
        prog_img[4] = enc_add(5'd3, 5'd2, 5'd5);
        run_scenario("secret address", 16);
        dmem_img[1][2] = 32'd20;   // same pointer, pointed-to data still differs
        run_scenario("equal pointer", 16);

        repeat (6) begin
            randomize_run();
            run_scenario("random", 20);   // wraps past pc 15
        end

        dmem_img[0][2] = 32'd20;
        dmem_img[1][2] = 32'd36;
        fill_nops();
        prog_img[1] = enc_lw(5'd1, 5'd0, 12'd8);
        prog_img[3] = enc_lw(5'd2, 5'd1, 12'd0);
        run_scenario("sticky", 16);
        repeat (4) begin
            next_cycle();
            check("leak with run low", 32'd1, lockstep_pkg::word_t'(leak));
        end
        fill_nops();
        prog_img[0] = enc_addi(5'd9, 5'd0, 12'd3);
        prog_img[1] = enc_lw(5'd1, 5'd0, 12'd8);   // load buffers agree again
        load_program();
        run = 1'b1;
        repeat (17) next_cycle();
        run = 1'b0;
        next_cycle();
        check("leak after further program", 32'd1, lockstep_pkg::word_t'(leak));
        check("leak_pc after further program", 32'd12, leak_pc);
        apply_reset();
        check("leak after reset", 32'd0, lockstep_pkg::word_t'(leak));
        check("leak_pc after reset", 32'd0, leak_pc);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/lockstep_top.sv ====
// top of the harness; retire ports follow copy 0 only, dmem writes go to the copy in dmem_copy
`default_nettype none

module lockstep_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    prog_we,
    input  lockstep_pkg::mem_idx_t  prog_addr,
    input  lockstep_pkg::word_t     prog_data,
    input  logic                    dmem_we,
    input  lockstep_pkg::copy_idx_t dmem_copy,
    input  lockstep_pkg::mem_idx_t  dmem_addr,
    input  lockstep_pkg::word_t     dmem_data,
    input  logic                    run,
    output logic                    retire_valid,
    output lockstep_pkg::reg_addr_t retire_addr,
    output lockstep_pkg::word_t     retire_data,
    output logic                    leak,
    output lockstep_pkg::word_t     leak_pc
);

    lockstep_pkg::word_t fetch_addr [lockstep_pkg::num_copies];
    lockstep_pkg::word_t fetch_inst [lockstep_pkg::num_copies];

    core_obs_if obs [lockstep_pkg::num_copies] ();

    program_store u_program_store (
        .clk        (clk),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .fetch_addr (fetch_addr),
        .fetch_inst (fetch_inst)
    );

    for (genvar c = 0; c < lockstep_pkg::num_copies; c++) begin : g_copy
        lockstep_pkg::mem_idx_t dmem_raddr;
        lockstep_pkg::word_t    dmem_rdata;
        logic                   copy_we;

        assign copy_we = dmem_we && dmem_copy == lockstep_pkg::copy_idx_t'(c);

        lockstep_core u_core (
            .clk        (clk),
            .reset      (reset),
            .run        (run),
            .fetch_inst (fetch_inst[c]),
            .dmem_rdata (dmem_rdata),
            .fetch_addr (fetch_addr[c]),
            .dmem_raddr (dmem_raddr),
            .obs        (obs[c])
        );

        secret_dmem u_dmem (
            .clk   (clk),
            .we    (copy_we),
            .waddr (dmem_addr),
            .wdata (dmem_data),
            .raddr (dmem_raddr),
            .rdata (dmem_rdata)
        );
    end

    divergence_checker u_checker (
        .clk     (clk),
        .reset   (reset),
        .obs     (obs),
        .leak    (leak),
        .leak_pc (leak_pc)
    );

    assign retire_valid = obs[0].wb_en;   // copy 0 writeback
    assign retire_addr  = obs[0].wb_addr;
    assign retire_data  = obs[0].wb_data;

endmodule

`default_nettype wire

// ==== logic/divergence_checker.sv ====
// compares load buffers of all copies against copy 0; leak is sticky until reset, data may differ
`default_nettype none

module divergence_checker (
    input  logic                clk,
    input  logic                reset,
    core_obs_if.check           obs [lockstep_pkg::num_copies],
    output logic                leak,
    output lockstep_pkg::word_t leak_pc
);

    logic [lockstep_pkg::num_copies-1:1] differs;   // one bit per compared copy
    lockstep_pkg::word_t                 last_pc;   // copy 0 pc one cycle back

    for (genvar c = 1; c < lockstep_pkg::num_copies; c++) begin : g_cmp
        logic valid_diff;
        logic addr_diff;

        assign valid_diff = obs[c].lb_valid != obs[0].lb_valid;
        // load data alone is the secret itself, only the address counts
        assign addr_diff  = obs[c].lb_valid && obs[0].lb_valid &&
                            obs[c].lb_addr != obs[0].lb_addr;
        assign differs[c] = valid_diff || addr_diff;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            leak    <= 1'b0;
            leak_pc <= '0;
            last_pc <= '0;
        end else begin
            last_pc <= obs[0].pc;   // load buffers change one edge after the load executes
            if (!leak && |differs) begin
                leak    <= 1'b1;
                leak_pc <= last_pc;   // pc of the offending load
            end
        end
    end

    // once set only reset may clear it
    a_leak_sticky : assert property (
        @(posedge clk) $fell(leak) |-> $past(reset)
    ) else $error("leak dropped without reset");

endmodule

`default_nettype wire

// ==== logic/lockstep_core.sv ====
// two-stage core for addi/add/lw only, other encodings run as nop; no stores, branches or hazards
`default_nettype none

module lockstep_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   run,
    input  lockstep_pkg::word_t    fetch_inst,
    input  lockstep_pkg::word_t    dmem_rdata,
    output lockstep_pkg::word_t    fetch_addr,
    output lockstep_pkg::mem_idx_t dmem_raddr,
    core_obs_if.core               obs
);

    lockstep_pkg::word_t       pc;         // fetch pc
    lockstep_pkg::word_t       ex_pc;      // pc of ex_inst
    lockstep_pkg::word_t       ex_inst;
    lockstep_pkg::word_t       regs [32];  // x0 never written

    lockstep_pkg::opcode_e     opcode;
    lockstep_pkg::inst_class_e inst_class;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    lockstep_pkg::reg_addr_t   rs1;
    lockstep_pkg::reg_addr_t   rs2;
    lockstep_pkg::reg_addr_t   rd;
    lockstep_pkg::word_t       imm_i;
    lockstep_pkg::word_t       rs1_val;
    lockstep_pkg::word_t       rs2_val;
    lockstep_pkg::word_t       alu_out;
    lockstep_pkg::word_t       wb_data;
    logic                      wb_en;

    logic                      lb_valid;
    lockstep_pkg::word_t       lb_addr;
    lockstep_pkg::word_t       lb_data;

    assign fetch_addr = pc;

    // stage two field split
    assign opcode = lockstep_pkg::opcode_e'(ex_inst[6:0]);
    assign funct3 = ex_inst[14:12];
    assign funct7 = ex_inst[31:25];
    assign rd     = ex_inst[11:7];
    assign rs1    = ex_inst[19:15];
    assign rs2    = ex_inst[24:20];
    assign imm_i  = {{20{ex_inst[31]}}, ex_inst[31:20]};   // sign extended I-type

    always_comb begin
        inst_class = lockstep_pkg::cls_nop;
        case (opcode)
            lockstep_pkg::op_imm: begin
                if (funct3 == 3'b000) inst_class = lockstep_pkg::cls_addi;
            end
            lockstep_pkg::op_reg: begin
                if (funct3 == 3'b000 && funct7 == 7'd0) inst_class = lockstep_pkg::cls_add;
            end
            lockstep_pkg::op_load: begin
                if (funct3 == 3'b010) inst_class = lockstep_pkg::cls_load;   // lw only
            end
            default: inst_class = lockstep_pkg::cls_nop;
        endcase
    end

    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];

    // addi and the load address share rs1 + imm
    assign alu_out = (inst_class == lockstep_pkg::cls_add) ? rs1_val + rs2_val
                                                           : rs1_val + imm_i;

    assign dmem_raddr = alu_out[5:2];
    assign wb_data    = (inst_class == lockstep_pkg::cls_load) ? dmem_rdata : alu_out;

    // nothing retires while run is low
    assign wb_en = run && inst_class != lockstep_pkg::cls_nop && rd != 5'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            ex_pc    <= '0;
            ex_inst  <= lockstep_pkg::nop_inst;
            lb_valid <= 1'b0;
            lb_addr  <= '0;
            lb_data  <= '0;
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else if (run) begin
            pc      <= lockstep_pkg::word_t'({pc[5:2] + 4'd1, 2'b00});   // wraps at 16 words
            ex_pc   <= pc;
            ex_inst <= fetch_inst;
            if (wb_en) begin
                regs[rd] <= wb_data;
            end
            if (inst_class == lockstep_pkg::cls_load) begin   // also for rd = x0
                lb_valid <= 1'b1;
                lb_addr  <= alu_out;
                lb_data  <= dmem_rdata;
            end
        end
    end

    assign obs.pc       = ex_pc;
    assign obs.inst     = ex_inst;
    assign obs.wb_en    = wb_en;
    assign obs.wb_addr  = rd;
    assign obs.wb_data  = wb_data;
    assign obs.lb_valid = lb_valid;
    assign obs.lb_addr  = lb_addr;
    assign obs.lb_data  = lb_data;

    // x0 reads as zero, so no writeback ever reached it
    a_x0_zero : assert property (
        @(posedge clk) disable iff (reset) regs[0] == '0
    ) else $error("x0 holds %h after a writeback", regs[0]);

endmodule

`default_nettype wire

// ==== logic/secret_dmem.sv ====
// private 16-word data memory of one copy, no reset, word addressed; read is combinational
`default_nettype none

module secret_dmem (
    input  logic                   clk,
    input  logic                   we,      // already gated per copy at the top
    input  lockstep_pkg::mem_idx_t waddr,
    input  lockstep_pkg::word_t    wdata,
    input  lockstep_pkg::mem_idx_t raddr,
    output lockstep_pkg::word_t    rdata
);

    // secret words, may differ from the other copies
    lockstep_pkg::word_t mem [lockstep_pkg::dmem_words];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];   // load port

endmodule

`default_nettype wire

// ==== logic/program_store.sv ====
// shared 16-word program, contents undefined until written; fetch is combinational on addr bits 5:2
`default_nettype none

module program_store (
    input  logic                    clk,
    input  logic                    prog_we,
    input  lockstep_pkg::mem_idx_t  prog_addr,
    input  lockstep_pkg::word_t     prog_data,
    input  lockstep_pkg::word_t     fetch_addr [lockstep_pkg::num_copies],
    output lockstep_pkg::word_t     fetch_inst [lockstep_pkg::num_copies]
);

    lockstep_pkg::word_t mem [lockstep_pkg::prog_words];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;   // visible from the next edge
        end
    end

    // one independent read port per copy
    for (genvar c = 0; c < lockstep_pkg::num_copies; c++) begin : g_fetch
        lockstep_pkg::mem_idx_t idx;

        assign idx           = fetch_addr[c][5:2];   // pc wraps over 16 words
        assign fetch_inst[c] = mem[idx];

        // the core pc only ever steps by whole words
        a_fetch_aligned : assert property (
            @(posedge clk) !$isunknown(fetch_addr[c]) |-> fetch_addr[c][1:0] == 2'b00
        ) else $error("copy %0d fetch address %h not word aligned", c, fetch_addr[c]);
    end

endmodule

`default_nettype wire

// ==== logic/core_obs_if.sv ====
// per-copy observation bundle; every signal is driven by the core, the checker only reads
`default_nettype none

interface core_obs_if;

    lockstep_pkg::word_t     pc;        // pc of the executing instruction
    lockstep_pkg::word_t     inst;
    logic                    wb_en;     // writes a nonzero rd this cycle
    lockstep_pkg::reg_addr_t wb_addr;
    lockstep_pkg::word_t     wb_data;
    logic                    lb_valid;  // last-load buffer
    lockstep_pkg::word_t     lb_addr;
    lockstep_pkg::word_t     lb_data;

    modport core (
        output pc, inst, wb_en, wb_addr, wb_data, lb_valid, lb_addr, lb_data
    );

    modport check (
        input pc, inst, wb_en, wb_addr, wb_data, lb_valid, lb_addr, lb_data
    );

endinterface

`default_nettype wire

// ==== logic/lockstep_pkg.sv ====
// shared sizes and types; num_copies may grow, the 16-word memories and 32-bit words are fixed
`default_nettype none

package lockstep_pkg;

    localparam int num_copies = 2;   // lockstep copies, 2 or more
    localparam int prog_words = 16;
    localparam int dmem_words = 16;
    localparam int xlen       = 32;

    // dmem_copy select width, at least one bit
    localparam int copy_w = (num_copies > 1) ? $clog2(num_copies) : 1;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

    typedef logic [xlen-1:0]   word_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [3:0]        mem_idx_t;   // word index, both memories
    typedef logic [copy_w-1:0] copy_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_imm  = 7'b0010011,
        op_reg  = 7'b0110011,
        op_load = 7'b0000011
    } opcode_e;

    typedef enum logic [1:0] {
        cls_addi,
        cls_add,
        cls_load,
        cls_nop    // anything unsupported
    } inst_class_e;

endpackage

`default_nettype wire
